// File: source/mmu_settings.svh
// width, entry count and xlen constants of the data-side sv39 mmu

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// virtual address width for sv39
`define MMU_VLEN 39

// physical address and page number widths
`define MMU_PLEN 56
`define MMU_PPNW 44

// address space identifier width
`define MMU_ASIDW 8

// width of the exception value reported with a fault
`define MMU_XLEN 64

// fully associative data tlb size
`define MMU_TLB_ENTRIES 8

`endif

// File: source/mmu_pkg.sv
// sv39 page table entry, privilege, exception cause, page size
// and address types shared by the data mmu

`include "mmu_settings.svh"

package mmu_pkg;

  // virtual page number, split into the three sv39 levels
  typedef struct packed {
    logic [8:0] vpn2;
    logic [8:0] vpn1;
    logic [8:0] vpn0;
  } vpn_t;

  typedef logic [`MMU_PPNW-1:0]  ppn_t;
  typedef logic [`MMU_ASIDW-1:0] asid_t;
  typedef logic [`MMU_VLEN-1:0]  vaddr_t;
  typedef logic [`MMU_PLEN-1:0]  paddr_t;

  // leaf pte content kept in the tlb, rsw bits dropped
  typedef struct packed {
    ppn_t ppn;
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_t;

  // privilege encoding as in mstatus.mpp
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // mcause codes of the two data page faults
  typedef enum logic [5:0] {
    LOAD_PAGE_FAULT  = 6'd13,
    STORE_PAGE_FAULT = 6'd15
  } exc_cause_t;

  typedef enum logic [1:0] {
    PAGE_4K = 2'd0,
    PAGE_2M = 2'd1,
    PAGE_1G = 2'd2
  } page_size_t;

endpackage

// File: source/tlb_if.sv
// tlb write bus from the refill unit and tlb match bus
// towards the translation stage

`timescale 1ns/1ps
`include "mmu_settings.svh"

// --------------------------------------------------------------------------
// write side: refill broadcasts one entry, entries report their valid bit
// --------------------------------------------------------------------------
interface tlb_wr_if import mmu_pkg::*; ();

  // one write enable per entry, at most one set
  logic [`MMU_TLB_ENTRIES-1:0] wr_en;
  vpn_t                        wr_vpn;
  asid_t                       wr_asid;
  pte_t                        wr_pte;
  page_size_t                  wr_size;
  // occupancy, used for victim selection
  logic [`MMU_TLB_ENTRIES-1:0] valid;

  modport refill (output wr_en, wr_vpn, wr_asid, wr_pte, wr_size, input valid);
  modport entry  (input wr_en, wr_vpn, wr_asid, wr_pte, wr_size, output valid);

endinterface

// --------------------------------------------------------------------------
// lookup side: translation stage drives the tag, each entry answers
// --------------------------------------------------------------------------
interface tlb_match_if import mmu_pkg::*; ();

  vpn_t                        lu_vpn;
  asid_t                       lu_asid;
  // per-entry hit and content slots
  logic [`MMU_TLB_ENTRIES-1:0] hit;
  pte_t                        pte  [`MMU_TLB_ENTRIES];
  page_size_t                  size [`MMU_TLB_ENTRIES];

  modport entry  (input lu_vpn, lu_asid, output hit, pte, size);
  modport lookup (output lu_vpn, lu_asid, input hit, pte, size);

endinterface

// File: source/tlb_refill.sv
// tlb refill unit with victim selection and replacement pointer

`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb_refill import mmu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // update port from the walker side
  input  logic       upd_valid_i,
  input  vpn_t       upd_vpn_i,
  input  asid_t      upd_asid_i,
  input  pte_t       upd_pte_i,
  input  page_size_t upd_size_i,
  tlb_wr_if.refill   wr
);

  localparam int unsigned N    = `MMU_TLB_ENTRIES;
  localparam int unsigned IDXW = $clog2(N);

  logic [IDXW-1:0] repl_ptr_q;
  logic [IDXW-1:0] victim;
  logic            any_invalid;
  logic            accept;
  logic [N-1:0]    wr_en;

  // updates colliding with a flush are lost
  assign accept = upd_valid_i & ~flush_i;

  // lowest free slot wins and the round-robin pointer is the fallback
  always_comb begin
    victim      = repl_ptr_q;
    any_invalid = 1'b0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!wr.valid[i]) begin
        victim      = IDXW'(i);
        any_invalid = 1'b1;
      end
    end
  end

  always_comb begin
    wr_en = '0;
    if (accept) begin
      wr_en[victim] = 1'b1;
    end
  end

  // write data goes to every entry and the enable picks one
  assign wr.wr_en   = wr_en;
  assign wr.wr_vpn  = upd_vpn_i;
  assign wr.wr_asid = upd_asid_i;
  assign wr.wr_pte  = upd_pte_i;
  assign wr.wr_size = upd_size_i;

  // pointer only moves when a valid entry gets evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      repl_ptr_q <= '0;
    end else if (accept && !any_invalid) begin
      if (repl_ptr_q == IDXW'(N - 1)) begin
        repl_ptr_q <= '0;
      end else begin
        repl_ptr_q <= repl_ptr_q + 1'b1;
      end
    end
  end

  // an accepted update shows up as a valid entry one edge later
  a_wr_lands: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> ((wr.valid & $past(wr.wr_en)) != '0));

endmodule

// File: source/tlb_entry.sv
// single data tlb entry with lookup match and flush match

`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb_entry import mmu_pkg::*; #(
  parameter int unsigned IDX = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  asid_t      flush_asid_i,
  input  vaddr_t     flush_vaddr_i,
  tlb_wr_if.entry    wr,
  tlb_match_if.entry lu
);

  logic       valid_q;
  vpn_t       vpn_q;
  asid_t      asid_q;
  page_size_t size_q;
  pte_t       pte_q;

  vpn_t flush_vpn;
  logic flush_va_nz;
  logic flush_asid_nz;
  logic flush_hit;

  // tag compare, lower levels masked for superpages
  function automatic logic tag_match(vpn_t vpn);
    logic l2_ok;
    logic l1_ok;
    logic l0_ok;
    l2_ok = (vpn.vpn2 == vpn_q.vpn2);
    l1_ok = (size_q == PAGE_1G) || (vpn.vpn1 == vpn_q.vpn1);
    l0_ok = (size_q != PAGE_4K) || (vpn.vpn0 == vpn_q.vpn0);
    return l2_ok & l1_ok & l0_ok;
  endfunction

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------
  // global pages ignore the asid
  assign lu.hit[IDX]  = valid_q && ((asid_q == lu.lu_asid) || pte_q.g) && tag_match(lu.lu_vpn);
  assign lu.pte[IDX]  = pte_q;
  assign lu.size[IDX] = size_q;

  assign wr.valid[IDX] = valid_q;

  // --------------------------------------------------------------------------
  // flush
  // --------------------------------------------------------------------------
  assign flush_vpn     = flush_vaddr_i[`MMU_VLEN-1:12];
  assign flush_va_nz   = |flush_vaddr_i;
  assign flush_asid_nz = |flush_asid_i;

  // zero fields act as wildcards, asid flushes spare global pages
  assign flush_hit = (!flush_va_nz || tag_match(flush_vpn))
                  && (!flush_asid_nz || ((asid_q == flush_asid_i) && !pte_q.g));

  // refill holds wr_en low during a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i && flush_hit) begin
      valid_q <= 1'b0;
    end else if (wr.wr_en[IDX]) begin
      valid_q <= 1'b1;
    end
  end

  // tag and content
  always_ff @(posedge clk_i) begin
    if (wr.wr_en[IDX]) begin
      vpn_q  <= wr.wr_vpn;
      asid_q <= wr.wr_asid;
      size_q <= wr.wr_size;
      pte_q  <= wr.wr_pte;
    end
  end

endmodule

// File: source/lsu_translate.sv
// load/store translation stage with hit select, same-cycle ppn,
// request register, paddr composition and page-fault checks

`timescale 1ns/1ps
`include "mmu_settings.svh"

module lsu_translate import mmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // request from the lsu
  input  logic                 lsu_req_i,
  input  vaddr_t               lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  // csr state
  input  logic                 en_translation_i,
  input  priv_lvl_t            priv_lvl_i,
  input  logic                 sum_i,
  input  asid_t                asid_i,
  tlb_match_if.lookup          lu,
  // same cycle
  output logic                 dtlb_hit_o,
  output ppn_t                 dtlb_ppn_o,
  // one cycle later
  output logic                 valid_o,
  output paddr_t               paddr_o,
  output logic                 ex_valid_o,
  output exc_cause_t           ex_cause_o,
  output logic [`MMU_XLEN-1:0] ex_tval_o
);

  localparam int unsigned N = `MMU_TLB_ENTRIES;

  logic       hit_any;
  pte_t       pte_sel;
  page_size_t size_sel;

  logic       req_q;
  logic       hit_q;
  logic       store_q;
  vaddr_t     vaddr_q;
  pte_t       pte_q;
  page_size_t size_q;

  logic       perm_err;
  logic       store_err;

  // --------------------------------------------------------------------------
  // cycle 0 tlb lookup
  // --------------------------------------------------------------------------
  assign lu.lu_vpn  = lsu_vaddr_i[`MMU_VLEN-1:12];
  assign lu.lu_asid = asid_i;

  assign hit_any = |lu.hit;

  // at most one entry hits at a time
  always_comb begin
    pte_sel  = '0;
    size_sel = PAGE_4K;
    for (int i = 0; i < N; i++) begin
      if (lu.hit[i]) begin
        pte_sel  = lu.pte[i];
        size_sel = lu.size[i];
      end
    end
  end

  // always ready when not translating
  assign dtlb_hit_o = en_translation_i ? hit_any : 1'b1;

  always_comb begin
    dtlb_ppn_o = ppn_t'(lsu_vaddr_i[`MMU_VLEN-1:12]);
    if (en_translation_i) begin
      dtlb_ppn_o = pte_sel.ppn;
      // superpage low ppn bits come from the vaddr
      if (size_sel == PAGE_2M) begin
        dtlb_ppn_o[8:0] = lsu_vaddr_i[20:12];
      end
      if (size_sel == PAGE_1G) begin
        dtlb_ppn_o[17:0] = lsu_vaddr_i[29:12];
      end
    end
  end

  // --------------------------------------------------------------------------
  // request register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i;
      hit_q <= hit_any;
    end
  end

  always_ff @(posedge clk_i) begin
    store_q <= lsu_is_store_i;
    vaddr_q <= lsu_vaddr_i;
    pte_q   <= pte_sel;
    size_q  <= size_sel;
  end

  // --------------------------------------------------------------------------
  // cycle 1 address and page-fault checks
  // --------------------------------------------------------------------------
  always_comb begin
    paddr_o = paddr_t'(vaddr_q);
    valid_o = req_q;
    if (en_translation_i) begin
      paddr_o = {pte_q.ppn, vaddr_q[11:0]};
      if (size_q == PAGE_2M) begin
        paddr_o[20:12] = vaddr_q[20:12];
      end
      if (size_q == PAGE_1G) begin
        paddr_o[29:12] = vaddr_q[29:12];
      end
      // a miss returns no response
      valid_o = req_q & hit_q;
    end
  end

  // s-mode on a user page needs sum, u-mode needs a user page
  assign perm_err = en_translation_i
                 && (((priv_lvl_i == PRIV_LVL_S) && !sum_i && pte_q.u)
                 ||  ((priv_lvl_i == PRIV_LVL_U) && !pte_q.u));

  // stores also need write permission and a set dirty bit
  assign store_err = perm_err || !pte_q.w || !pte_q.d;

  assign ex_valid_o = en_translation_i && req_q && hit_q && (store_q ? store_err : perm_err);
  assign ex_cause_o = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
  assign ex_tval_o  = {{(`MMU_XLEN - `MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};

  // refill never creates overlapping entries
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(lu.hit));

endmodule

// File: source/dmmu.sv
// data mmu top level with refill unit, tlb entries and translation stage

`timescale 1ns/1ps
`include "mmu_settings.svh"

module dmmu import mmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // lsu request
  input  logic                 lsu_req_i,
  input  vaddr_t               lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  // csr state
  input  logic                 en_translation_i,
  input  priv_lvl_t            priv_lvl_i,
  input  logic                 sum_i,
  input  asid_t                asid_i,
  // same cycle response
  output logic                 dtlb_hit_o,
  output ppn_t                 dtlb_ppn_o,
  // registered response
  output logic                 valid_o,
  output paddr_t               paddr_o,
  output logic                 ex_valid_o,
  output exc_cause_t           ex_cause_o,
  output logic [`MMU_XLEN-1:0] ex_tval_o,
  // refill from the walker
  input  logic                 upd_valid_i,
  input  vpn_t                 upd_vpn_i,
  input  asid_t                upd_asid_i,
  input  pte_t                 upd_pte_i,
  input  page_size_t           upd_size_i,
  // sfence.vma
  input  logic                 flush_i,
  input  asid_t                flush_asid_i,
  input  vaddr_t               flush_vaddr_i
);

  tlb_wr_if    wr_bus ();
  tlb_match_if match_bus ();

  tlb_refill u_refill (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .flush_i     ( flush_i     ),
    .upd_valid_i ( upd_valid_i ),
    .upd_vpn_i   ( upd_vpn_i   ),
    .upd_asid_i  ( upd_asid_i  ),
    .upd_pte_i   ( upd_pte_i   ),
    .upd_size_i  ( upd_size_i  ),
    .wr          ( wr_bus      )
  );

  // fully associative array
  for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_entry
    tlb_entry #(.IDX(i)) u_entry (
      .clk_i         ( clk_i         ),
      .rst_ni        ( rst_ni        ),
      .flush_i       ( flush_i       ),
      .flush_asid_i  ( flush_asid_i  ),
      .flush_vaddr_i ( flush_vaddr_i ),
      .wr            ( wr_bus        ),
      .lu            ( match_bus     )
    );
  end

  lsu_translate u_translate (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .lsu_req_i        ( lsu_req_i        ),
    .lsu_vaddr_i      ( lsu_vaddr_i      ),
    .lsu_is_store_i   ( lsu_is_store_i   ),
    .en_translation_i ( en_translation_i ),
    .priv_lvl_i       ( priv_lvl_i       ),
    .sum_i            ( sum_i            ),
    .asid_i           ( asid_i           ),
    .lu               ( match_bus        ),
    .dtlb_hit_o       ( dtlb_hit_o       ),
    .dtlb_ppn_o       ( dtlb_ppn_o       ),
    .valid_o          ( valid_o          ),
    .paddr_o          ( paddr_o          ),
    .ex_valid_o       ( ex_valid_o       ),
    .ex_cause_o       ( ex_cause_o       ),
    .ex_tval_o        ( ex_tval_o        )
  );

endmodule

// File: verif/tb_clk_gen.sv
// clock and reset generator of the testbench

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, low in the first half period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verif/tb_dmmu.sv
// testbench of the data mmu with random stimulus, a reference tlb model,
// typed compare tasks and a cycle timeout

`timescale 1ns/1ps
`include "mmu_settings.svh"

module tb_dmmu import mmu_pkg::*; ();

  localparam int N          = `MMU_TLB_ENTRIES;
  localparam int NUM_CYCLES = 2000;
  // half the run length as margin
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 2;

  logic       clk_i;
  logic       rst_ni;
  // dut inputs
  logic       lsu_req;
  logic       lsu_is_store;
  logic       en_translation;
  logic       sum;
  logic       upd_valid;
  logic       flush;
  vaddr_t     lsu_vaddr;
  vaddr_t     flush_vaddr;
  priv_lvl_t  priv_lvl;
  asid_t      asid;
  asid_t      upd_asid;
  asid_t      flush_asid;
  vpn_t       upd_vpn;
  pte_t       upd_pte;
  page_size_t upd_size;
  // dut outputs
  logic                 dtlb_hit;
  ppn_t                 dtlb_ppn;
  logic                 valid;
  paddr_t               paddr;
  logic                 ex_valid;
  exc_cause_t           ex_cause;
  logic [`MMU_XLEN-1:0] ex_tval;

  // reference tlb
  logic       m_valid [N];
  vpn_t       m_vpn   [N];
  asid_t      m_asid  [N];
  page_size_t m_size  [N];
  pte_t       m_pte   [N];
  int         m_ptr;

  // prediction for the registered outputs, made one cycle earlier
  logic      exp_req;
  logic      exp_hit;
  logic      exp_store;
  logic      exp_en;
  logic      exp_sum;
  priv_lvl_t exp_priv;
  vaddr_t    exp_vaddr;
  ppn_t      exp_ppn;
  pte_t      exp_pte;

  integer seed;
  logic   prev_req;
  int     cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(5)) u_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  dmmu dut0 (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .lsu_req_i        ( lsu_req        ),
    .lsu_vaddr_i      ( lsu_vaddr      ),
    .lsu_is_store_i   ( lsu_is_store   ),
    .en_translation_i ( en_translation ),
    .priv_lvl_i       ( priv_lvl       ),
    .sum_i            ( sum            ),
    .asid_i           ( asid           ),
    .dtlb_hit_o       ( dtlb_hit       ),
    .dtlb_ppn_o       ( dtlb_ppn       ),
    .valid_o          ( valid          ),
    .paddr_o          ( paddr          ),
    .ex_valid_o       ( ex_valid       ),
    .ex_cause_o       ( ex_cause       ),
    .ex_tval_o        ( ex_tval        ),
    .upd_valid_i      ( upd_valid      ),
    .upd_vpn_i        ( upd_vpn        ),
    .upd_asid_i       ( upd_asid       ),
    .upd_pte_i        ( upd_pte        ),
    .upd_size_i       ( upd_size       ),
    .flush_i          ( flush          ),
    .flush_asid_i     ( flush_asid     ),
    .flush_vaddr_i    ( flush_vaddr    )
  );

  // --------------------------------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic report_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, name, act, exp);
      report_failure();
    end
  endtask

  task automatic check_ppn(string name, ppn_t act, ppn_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      report_failure();
    end
  endtask

  task automatic check_paddr(string name, paddr_t act, paddr_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      report_failure();
    end
  endtask

  task automatic check_cause(string name, exc_cause_t act, exc_cause_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      report_failure();
    end
  endtask

  task automatic check_tval(string name, logic [`MMU_XLEN-1:0] act,
                            logic [`MMU_XLEN-1:0] exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      report_failure();
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic int rnd(int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  // levels below the page size are ignored
  function automatic logic region_match(vpn_t a, vpn_t b, page_size_t sz);
    return (a.vpn2 == b.vpn2) && ((sz == PAGE_1G) || (a.vpn1 == b.vpn1))
        && ((sz != PAGE_4K) || (a.vpn0 == b.vpn0));
  endfunction

  function automatic int model_lookup(vpn_t vpn, asid_t as);
    int idx;
    idx = -1;
    for (int i = 0; i < N; i++) begin
      if (m_valid[i] && ((m_asid[i] == as) || m_pte[i].g)
          && region_match(vpn, m_vpn[i], m_size[i])) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // new entry may not overlap one that is visible under the same asid
  function automatic logic conflicts(vpn_t vpn, asid_t as, page_size_t sz, logic g);
    logic c;
    c = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (m_valid[i] && ((m_asid[i] == as) || m_pte[i].g || g)
          && region_match(vpn, m_vpn[i], (sz > m_size[i]) ? sz : m_size[i])) begin
        c = 1'b1;
      end
    end
    return c;
  endfunction

  // zero asid or zero vaddr act as wildcards, asid flushes spare globals
  task automatic model_flush(asid_t fa, vaddr_t fv);
    vpn_t fvpn;
    fvpn = fv[`MMU_VLEN-1:12];
    for (int i = 0; i < N; i++) begin
      if (((fv == '0) || region_match(fvpn, m_vpn[i], m_size[i]))
          && ((fa == '0) || ((m_asid[i] == fa) && !m_pte[i].g))) begin
        m_valid[i] = 1'b0;
      end
    end
  endtask

  // lowest free slot, else the round-robin pointer
  task automatic model_refill(vpn_t vpn, asid_t as, pte_t pte, page_size_t sz);
    int v;
    v = -1;
    for (int i = N - 1; i >= 0; i--) begin
      if (!m_valid[i]) begin
        v = i;
      end
    end
    if (v < 0) begin
      v = m_ptr;
      m_ptr = (m_ptr + 1) % N;
    end
    m_valid[v] = 1'b1;
    m_vpn[v]   = vpn;
    m_asid[v]  = as;
    m_pte[v]   = pte;
    m_size[v]  = sz;
  endtask

  // superpage low ppn fields come from the vaddr
  function automatic ppn_t compose_ppn(pte_t pte, page_size_t sz, vaddr_t va);
    ppn_t p;
    p = pte.ppn;
    if (sz == PAGE_2M) begin
      p[8:0] = va[20:12];
    end
    if (sz == PAGE_1G) begin
      p[17:0] = va[29:12];
    end
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  // small field pools keep the hit rate up, 1ff exercises sign extension
  function automatic vpn_t pick_vpn();
    vpn_t v;
    v.vpn2 = (rnd(4) == 3) ? 9'h1ff : 9'(rnd(3));
    v.vpn1 = 9'(rnd(4));
    v.vpn0 = 9'(rnd(4));
    return v;
  endfunction

  // half the time aim inside a resident entry
  function automatic vaddr_t pick_vaddr();
    vpn_t v;
    int   i;
    v = pick_vpn();
    i = rnd(N);
    if ((rnd(2) == 0) && m_valid[i]) begin
      v.vpn2 = m_vpn[i].vpn2;
      v.vpn1 = (m_size[i] == PAGE_1G) ? 9'(rnd(512)) : m_vpn[i].vpn1;
      v.vpn0 = (m_size[i] != PAGE_4K) ? 9'(rnd(512)) : m_vpn[i].vpn0;
    end
    return {v, 12'(rnd(4096))};
  endfunction

  task automatic drive_random();
    int r;
    int form;
    // csr state held while a response is still pending
    if (!prev_req && (rnd(8) == 0)) begin
      r = rnd(3);
      en_translation = (rnd(8) != 0);
      priv_lvl = (r == 0) ? PRIV_LVL_U : ((r == 1) ? PRIV_LVL_S : PRIV_LVL_M);
      sum  = 1'(rnd(2));
      asid = asid_t'(rnd(4));
    end
    lsu_req      = (rnd(4) != 0);
    lsu_is_store = 1'(rnd(2));
    lsu_vaddr    = en_translation ? pick_vaddr() : vaddr_t'({$random(seed), $random(seed)});
    // sfence, one of four forms
    form        = rnd(4);
    flush       = (rnd(24) == 0);
    flush_asid  = form[0] ? asid_t'(1 + rnd(3)) : '0;
    flush_vaddr = form[1] ? (pick_vaddr() | vaddr_t'(1)) : '0;
    // walker refill
    r            = rnd(4);
    upd_vpn      = pick_vpn();
    upd_asid     = asid_t'(rnd(4));
    upd_size     = (r < 2) ? PAGE_4K : ((r == 2) ? PAGE_2M : PAGE_1G);
    upd_pte      = '0;
    upd_pte.ppn  = ppn_t'({$random(seed), $random(seed)});
    upd_pte.g    = (rnd(8) == 0);
    upd_pte.u    = 1'(rnd(2));
    upd_pte.w    = 1'(rnd(2));
    upd_pte.d    = 1'(rnd(2));
    upd_pte.x    = 1'(rnd(2));
    upd_pte.r    = 1'b1;
    upd_pte.a    = 1'b1;
    upd_pte.v    = 1'b1;
    upd_valid    = (rnd(3) == 0) && !conflicts(upd_vpn, upd_asid, upd_size, upd_pte.g);
  endtask

  // --------------------------------------------------------------------------
  // checking, sampled late in the cycle
  // --------------------------------------------------------------------------
  task automatic check_cycle();
    vpn_t vpn;
    int   idx;
    logic perm_err;
    logic exp_ex;
    logic exp_valid;
    // response to the request of the previous cycle
    exp_valid = exp_req && (!exp_en || exp_hit);
    perm_err  = exp_en && (((exp_priv == PRIV_LVL_S) && !exp_sum && exp_pte.u)
                       ||  ((exp_priv == PRIV_LVL_U) && !exp_pte.u));
    exp_ex    = exp_en && exp_req && exp_hit
             && (exp_store ? (perm_err || !exp_pte.w || !exp_pte.d) : perm_err);
    check_bit("valid_o", valid, exp_valid);
    check_bit("ex_valid_o", ex_valid, exp_ex);
    if (exp_valid) begin
      check_paddr("paddr_o", paddr,
                  exp_en ? {exp_ppn, exp_vaddr[11:0]} : paddr_t'(exp_vaddr));
    end
    if (exp_ex) begin
      check_cause("ex_cause_o", ex_cause, exp_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT);
      check_tval("ex_tval_o", ex_tval,
                 {{(`MMU_XLEN - `MMU_VLEN){exp_vaddr[`MMU_VLEN-1]}}, exp_vaddr});
    end
    // same cycle lookup
    vpn = lsu_vaddr[`MMU_VLEN-1:12];
    idx = model_lookup(vpn, asid);
    if (en_translation) begin
      check_bit("dtlb_hit_o", dtlb_hit, idx >= 0);
      if (idx >= 0) begin
        check_ppn("dtlb_ppn_o", dtlb_ppn, compose_ppn(m_pte[idx], m_size[idx], lsu_vaddr));
      end
    end else begin
      check_bit("dtlb_hit_o", dtlb_hit, 1'b1);
      check_ppn("dtlb_ppn_o", dtlb_ppn, ppn_t'(vpn));
    end
    exp_req   = lsu_req;
    exp_hit   = (idx >= 0);
    exp_store = lsu_is_store;
    exp_en    = en_translation;
    exp_priv  = priv_lvl;
    exp_sum   = sum;
    exp_vaddr = lsu_vaddr;
    if (idx >= 0) begin
      exp_pte = m_pte[idx];
      exp_ppn = compose_ppn(m_pte[idx], m_size[idx], lsu_vaddr);
    end
    prev_req = lsu_req;
    // table changes land at the coming edge, updates lose against a flush
    if (flush) begin
      model_flush(flush_asid, flush_vaddr);
    end else if (upd_valid) begin
      model_refill(upd_vpn, upd_asid, upd_pte, upd_size);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_failure();
    end
  end

  initial begin
    seed           = 16322;
    lsu_req        = 1'b0;
    lsu_is_store   = 1'b0;
    lsu_vaddr      = '0;
    en_translation = 1'b0;
    priv_lvl       = PRIV_LVL_S;
    sum            = 1'b0;
    asid           = '0;
    upd_valid      = 1'b0;
    upd_vpn        = '0;
    upd_asid       = '0;
    upd_pte        = '0;
    upd_size       = PAGE_4K;
    flush          = 1'b0;
    flush_asid     = '0;
    flush_vaddr    = '0;
    for (int i = 0; i < N; i++) begin
      m_valid[i] = 1'b0;
      m_vpn[i]   = '0;
      m_asid[i]  = '0;
      m_size[i]  = PAGE_4K;
      m_pte[i]   = '0;
    end
    m_ptr     = 0;
    prev_req  = 1'b0;
    exp_req   = 1'b0;
    exp_hit   = 1'b0;
    exp_store = 1'b0;
    exp_en    = 1'b0;
    exp_sum   = 1'b0;
    exp_priv  = PRIV_LVL_S;
    exp_vaddr = '0;
    exp_ppn   = '0;
    exp_pte   = '0;
    wait (rst_ni === 1'b1);
    repeat (NUM_CYCLES) begin
      @(posedge clk_i);
      #1;
      drive_random();
      #6;
      check_cycle();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: sim.f
+incdir+source
source/mmu_pkg.sv
source/tlb_if.sv
source/tlb_refill.sv
source/tlb_entry.sv
source/lsu_translate.sv
source/dmmu.sv
verif/tb_clk_gen.sv
verif/tb_dmmu.sv

// File: Makefile
# Verilator build and run of the data mmu testbench

VERILATOR ?= verilator
TOP       ?= tb_dmmu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Done: no errors" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
